/* hdl/back_end.sv */
`include "proc_consts.svh"

module back_end import isa_pkg::*, pipe_pkg::*; (
    input  logic                clock,
    input  logic                arst_n,
    dx_if.consumer              dx,
    output logic [`XLEN-1:0]    op_a,
    output logic [`XLEN-1:0]    op_b,
    input  logic [`XLEN-1:0]    alu_result,
    input  logic [`XLEN-1:0]    game_value,
    output logic [`XLEN-1:0]    address_dmem,
    output logic [`XLEN-1:0]    data,
    output logic                wren,
    input  logic [`XLEN-1:0]    q_dmem,
    output logic                ctrl_writeEnable,
    output logic [`REG_W-1:0]   ctrl_writeReg,
    output logic [`XLEN-1:0]    data_writeReg,
    output logic [`REG_W-1:0]   mem_rd,
    output logic                mem_is_load
);

    instr_t           ir;
    xm_t              xm;
    mw_t              mw;
    logic             mem_fwd_ok;
    fwd_sel_e         sel_a;
    fwd_sel_e         sel_b;
    logic [`XLEN-1:0] x_result;
    logic             store_fwd;

    assign ir = dx.dx_instr;

    // Memory stage first, then writeback, never register 0
    function automatic fwd_sel_e pick_src(
        input logic              used,
        input logic [`REG_W-1:0] src,
        input logic              m_ok,
        input logic [`REG_W-1:0] m_rd,
        input logic              w_ok,
        input logic [`REG_W-1:0] w_rd
    );
        if (!used || src == '0) begin
            return FWD_NONE;
        end
        if (m_ok && m_rd == src) begin
            return FWD_MEM;
        end
        if (w_ok && w_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // A load's memory-stage result is only its address
    assign mem_fwd_ok = writes_rd(xm.instr) && xm.instr.opcode != OP_LW;

    assign sel_a = pick_src(reads_rs(ir), ir.rs, mem_fwd_ok, xm.instr.rd,
                            ctrl_writeEnable, ctrl_writeReg);
    assign sel_b = pick_src(reads_rb(ir), src_b_reg(ir), mem_fwd_ok, xm.instr.rd,
                            ctrl_writeEnable, ctrl_writeReg);

    always_comb begin
        case (sel_a)
            FWD_MEM: op_a = xm.result;
            FWD_WB:  op_a = data_writeReg;
            default: op_a = dx.dx_a;
        endcase
        case (sel_b)
            FWD_MEM: op_b = xm.result;
            FWD_WB:  op_b = data_writeReg;
            default: op_b = dx.dx_b;
        endcase
    end

    assign x_result = is_game_op(ir) ? game_value : alu_result;

    // Load about to enter the memory stage feeds the decode stall
    assign mem_rd      = ir.rd;
    assign mem_is_load = ir.opcode == OP_LW;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm <= '0;
            mw <= '0;
        end else begin
            xm.instr      <= ir;
            xm.result     <= x_result;
            xm.store_data <= op_b;
            mw.instr      <= xm.instr;
            mw.result     <= xm.result;
            mw.load_data  <= q_dmem;
        end
    end

    // Store data may come from the instruction just ahead in writeback
    assign store_fwd    = ctrl_writeEnable && ctrl_writeReg == xm.instr.rd;
    assign address_dmem = xm.result;
    assign data         = store_fwd ? data_writeReg : xm.store_data;
    assign wren         = xm.instr.opcode == OP_SW;

    // Writeback
    assign ctrl_writeEnable = writes_rd(mw.instr) && mw.instr.rd != '0;
    assign ctrl_writeReg    = mw.instr.rd;
    assign data_writeReg    = (mw.instr.opcode == OP_LW) ? mw.load_data : mw.result;

    // A store never puts an unknown address or data on the bus
    a_store_known: assert property (@(posedge clock) disable iff (!arst_n)
        wren |-> !$isunknown({address_dmem, data}))
        else $error("Store with unknown address or data");

endmodule

/* hdl/dx_if.sv */
`include "proc_consts.svh"

// Decode/execute latch contents shared by the execute units
interface dx_if import isa_pkg::*; ();

    instr_t              dx_instr;
    logic [`XLEN-1:0]    dx_pc;
    logic [`XLEN-1:0]    dx_a;
    logic [`XLEN-1:0]    dx_b;

    modport producer (
        output dx_instr,
        output dx_pc,
        output dx_a,
        output dx_b
    );

    modport consumer (
        input dx_instr,
        input dx_pc,
        input dx_a,
        input dx_b
    );

endinterface

/* hdl/front_end.sv */
`include "proc_consts.svh"

module front_end import isa_pkg::*; (
    input  logic                clock,
    input  logic                arst_n,
    output logic [`XLEN-1:0]    address_imem,
    input  logic [`XLEN-1:0]    q_imem,
    output logic [`REG_W-1:0]   ctrl_readRegA,
    output logic [`REG_W-1:0]   ctrl_readRegB,
    input  logic [`XLEN-1:0]    data_readRegA,
    input  logic [`XLEN-1:0]    data_readRegB,
    input  logic                wb_en,
    input  logic [`REG_W-1:0]   wb_reg,
    input  logic [`XLEN-1:0]    wb_data,
    input  logic [`REG_W-1:0]   mem_rd,
    input  logic                mem_is_load,
    input  logic                branch_taken,
    input  logic [`XLEN-1:0]    branch_target,
    dx_if.producer              dx
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] fd_pc;
    instr_t           fd_instr;
    logic [`XLEN-1:0] reg_a;
    logic [`XLEN-1:0] reg_b;
    logic             hit_a;
    logic             hit_b;
    logic             stall;

    assign address_imem = pc;

    // Register read addresses
    assign ctrl_readRegA = fd_instr.rs;
    assign ctrl_readRegB = src_b_reg(fd_instr);

    // Write-through, the register file only updates at the edge
    assign reg_a = (wb_en && wb_reg == ctrl_readRegA) ? wb_data : data_readRegA;
    assign reg_b = (wb_en && wb_reg == ctrl_readRegB) ? wb_data : data_readRegB;

    // Load-use check against the load heading into memory
    // sw store data is covered by writeback forwarding in the memory stage
    assign hit_a = reads_rs(fd_instr) && fd_instr.rs == mem_rd;
    assign hit_b = reads_rb(fd_instr) && fd_instr.opcode != OP_SW && ctrl_readRegB == mem_rd;
    assign stall = mem_is_load && mem_rd != '0 && (hit_a || hit_b);

    // PC and fetch/decode instruction
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            fd_instr <= '0;
        end else if (branch_taken) begin
            pc       <= branch_target;
            fd_instr <= '0;
        end else if (!stall) begin
            pc       <= pc + `XLEN'(1);
            fd_instr <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!branch_taken && !stall) begin
            fd_pc <= pc;
        end
    end

    // Decode/execute instruction, bubble on stall or squash
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx.dx_instr <= '0;
        end else if (branch_taken || stall) begin
            dx.dx_instr <= '0;
        end else begin
            dx.dx_instr <= fd_instr;
        end
    end

    always_ff @(posedge clock) begin
        dx.dx_pc <= fd_pc;
        dx.dx_a  <= reg_a;
        dx.dx_b  <= reg_b;
    end

    a_pc_known: assert property (@(posedge clock) disable iff (!arst_n) !$isunknown(pc))
        else $error("PC went unknown");

endmodule

/* hdl/game_io.sv */
`include "proc_consts.svh"

module game_io import isa_pkg::*; (
    input  logic                clock,
    input  logic                arst_n,
    dx_if.consumer              dx,
    input  logic [`POS_W-1:0]   player_x,
    input  logic [`POS_W-1:0]   player_y,
    input  logic [`XLEN-1:0]    difficulty,
    output logic [`XLEN-1:0]    game_value
);

    logic [`XLEN-1:0] lfsr;

    // Right-shifting Galois LFSR, steps every cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= (lfsr >> 1) ^ ({`XLEN{lfsr[0]}} & `LFSR_TAPS);
        end
    end

    always_comb begin
        case (dx.dx_instr.alu_op)
            GAME_PLX: game_value = {{(`XLEN-`POS_W){1'b0}}, player_x};
            GAME_PLY: game_value = {{(`XLEN-`POS_W){1'b0}}, player_y};
            GAME_RND: game_value = lfsr;
            GAME_DIF: game_value = difficulty;
            default:  game_value = '0;
        endcase
    end

    // Zero is a lock-up state for this generator
    a_lfsr_live: assert property (@(posedge clock) disable iff (!arst_n) lfsr != '0)
        else $error("LFSR reached zero");

endmodule

/* hdl/int_alu.sv */
`include "proc_consts.svh"

module int_alu import isa_pkg::*; (
    dx_if.consumer              dx,
    input  logic [`XLEN-1:0]    op_a,
    input  logic [`XLEN-1:0]    op_b,
    output logic [`XLEN-1:0]    alu_result,
    output logic                branch_taken,
    output logic [`XLEN-1:0]    branch_target
);

    instr_t           ir;
    logic [`XLEN-1:0] imm;
    logic             is_jump;

    assign ir = dx.dx_instr;

    // Sign-extended immediate
    assign imm = {{(`XLEN-`IMM_W){ir[`IMM_W-1]}}, ir[`IMM_W-1:0]};

    always_comb begin
        // addi, lw and sw all compute rs + imm
        alu_result = op_a + imm;
        if (ir.opcode == OP_RTYPE) begin
            case (ir.alu_op)
                ALU_ADD: alu_result = op_a + op_b;
                ALU_SUB: alu_result = op_a - op_b;
                ALU_AND: alu_result = op_a & op_b;
                ALU_OR:  alu_result = op_a | op_b;
                ALU_SLL: alu_result = op_a << ir.shamt;
                ALU_SRA: alu_result = $signed(op_a) >>> ir.shamt;
                // Game reads are replaced downstream
                default: alu_result = '0;
            endcase
        end
    end

    assign is_jump = ir.opcode == OP_J;

    // op_b holds rd, op_a holds rs
    always_comb begin
        case (ir.opcode)
            OP_BNE:  branch_taken = op_b != op_a;
            OP_BLT:  branch_taken = $signed(op_b) < $signed(op_a);
            OP_J:    branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // j target is absolute
    assign branch_target = is_jump ? {{(`XLEN-`TGT_W){1'b0}}, ir[`TGT_W-1:0]}
                                   : dx.dx_pc + `XLEN'(1) + imm;

endmodule

/* hdl/isa_pkg.sv */
`include "proc_consts.svh"

package isa_pkg;

    typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    typedef enum logic [`ALUOP_MSB-`ALUOP_LSB:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_SLL  = 5'd4,
        ALU_SRA  = 5'd5,
        GAME_PLX = 5'd8,
        GAME_PLY = 5'd9,
        GAME_RND = 5'd10,
        GAME_DIF = 5'd11
    } alu_op_e;

    // Immediate and jump target overlay the low fields
    typedef struct packed {
        opcode_e                          opcode;
        logic [`RD_MSB-`RD_LSB:0]         rd;
        logic [`RS_MSB-`RS_LSB:0]         rs;
        logic [`RT_MSB-`RT_LSB:0]         rt;
        logic [`SHAMT_MSB-`SHAMT_LSB:0]   shamt;
        alu_op_e                          alu_op;
        logic [`ALUOP_LSB-1:0]            pad;
    } instr_t;

    function automatic logic is_game_op(instr_t i);
        return i.opcode == OP_RTYPE && i.alu_op inside {GAME_PLX, GAME_PLY, GAME_RND, GAME_DIF};
    endfunction

    function automatic logic writes_rd(instr_t i);
        return i.opcode inside {OP_RTYPE, OP_ADDI, OP_LW};
    endfunction

    function automatic logic reads_rs(instr_t i);
        return !is_game_op(i) && i.opcode inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_BLT};
    endfunction

    // Second operand is rt for R-type, rd for branches and stores
    function automatic logic reads_rb(instr_t i);
        if (i.opcode == OP_RTYPE) begin
            return !is_game_op(i) && !(i.alu_op inside {ALU_SLL, ALU_SRA});
        end
        return i.opcode inside {OP_BNE, OP_BLT, OP_SW};
    endfunction

    function automatic logic [`REG_W-1:0] src_b_reg(instr_t i);
        return (i.opcode == OP_RTYPE) ? i.rt : i.rd;
    endfunction

endpackage

/* hdl/pipe_pkg.sv */
`include "proc_consts.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Operand source chosen in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // Execute/memory latch
    typedef struct packed {
        instr_t              instr;
        logic [`XLEN-1:0]    result;
        logic [`XLEN-1:0]    store_data;
    } xm_t;

    // Memory/writeback latch
    typedef struct packed {
        instr_t              instr;
        logic [`XLEN-1:0]    result;
        logic [`XLEN-1:0]    load_data;
    } mw_t;

endpackage

/* hdl/processor.sv */
`include "proc_consts.svh"

module processor (
    input  logic                clock,
    input  logic                arst_n,
    output logic [`XLEN-1:0]    address_imem,
    input  logic [`XLEN-1:0]    q_imem,
    output logic [`XLEN-1:0]    address_dmem,
    output logic [`XLEN-1:0]    data,
    output logic                wren,
    input  logic [`XLEN-1:0]    q_dmem,
    output logic                ctrl_writeEnable,
    output logic [`REG_W-1:0]   ctrl_writeReg,
    output logic [`REG_W-1:0]   ctrl_readRegA,
    output logic [`REG_W-1:0]   ctrl_readRegB,
    output logic [`XLEN-1:0]    data_writeReg,
    input  logic [`XLEN-1:0]    data_readRegA,
    input  logic [`XLEN-1:0]    data_readRegB,
    input  logic [`POS_W-1:0]   player_x,
    input  logic [`POS_W-1:0]   player_y,
    input  logic [`XLEN-1:0]    difficulty
);

    logic [`XLEN-1:0]  op_a;
    logic [`XLEN-1:0]  op_b;
    logic [`XLEN-1:0]  alu_result;
    logic              branch_taken;
    logic [`XLEN-1:0]  branch_target;
    logic [`XLEN-1:0]  game_value;
    logic [`REG_W-1:0] mem_rd;
    logic              mem_is_load;

    dx_if u_dx ();

    // Fetch and decode
    front_end u_front_end (
        .clock          (clock),
        .arst_n         (arst_n),
        .address_imem   (address_imem),
        .q_imem         (q_imem),
        .ctrl_readRegA  (ctrl_readRegA),
        .ctrl_readRegB  (ctrl_readRegB),
        .data_readRegA  (data_readRegA),
        .data_readRegB  (data_readRegB),
        .wb_en          (ctrl_writeEnable),
        .wb_reg         (ctrl_writeReg),
        .wb_data        (data_writeReg),
        .mem_rd         (mem_rd),
        .mem_is_load    (mem_is_load),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .dx             (u_dx.producer)
    );

    int_alu u_int_alu (
        .dx             (u_dx.consumer),
        .op_a           (op_a),
        .op_b           (op_b),
        .alu_result     (alu_result),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    game_io u_game_io (
        .clock          (clock),
        .arst_n         (arst_n),
        .dx             (u_dx.consumer),
        .player_x       (player_x),
        .player_y       (player_y),
        .difficulty     (difficulty),
        .game_value     (game_value)
    );

    // Forwarding, memory and writeback
    back_end u_back_end (
        .clock            (clock),
        .arst_n           (arst_n),
        .dx               (u_dx.consumer),
        .op_a             (op_a),
        .op_b             (op_b),
        .alu_result       (alu_result),
        .game_value       (game_value),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg),
        .mem_rd           (mem_rd),
        .mem_is_load      (mem_is_load)
    );

endmodule

/* include/proc_consts.svh */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Datapath widths
`define XLEN 32
`define REG_W 5
`define POS_W 9

// Instruction fields
`define OPC_MSB 31
`define OPC_LSB 27
`define RD_MSB 26
`define RD_LSB 22
`define RS_MSB 21
`define RS_LSB 17
`define RT_MSB 16
`define RT_LSB 12
`define SHAMT_MSB 11
`define SHAMT_LSB 7
`define ALUOP_MSB 6
`define ALUOP_LSB 2
`define IMM_W 17
`define TGT_W 27

// Reset values
`define RESET_PC 32'd0
`define LFSR_SEED 32'h1
// Galois feedback for x^32 + x^22 + x^2 + x + 1
`define LFSR_TAPS 32'h8020_0003

`endif

/* processor.f */
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/dx_if.sv
hdl/front_end.sv
hdl/int_alu.sv
hdl/game_io.sv
hdl/back_end.sv
hdl/processor.sv
verification/tb_system_model.sv
verification/processor_tb.sv

/* verification/processor_tb.sv */
`include "proc_consts.svh"

module processor_tb import isa_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int LEN_ALU = 9;
    localparam int LEN_MEM = 8;
    localparam int LEN_BRANCH = 16;
    localparam int LEN_GAME = 7;
    localparam int LEN_RESET = 3;
    localparam int BUDGET_CYCLES = 4 * (LEN_ALU + LEN_MEM + LEN_BRANCH + LEN_GAME + LEN_RESET)
                                   + 5 * 20;
    localparam int WATCHDOG_CYCLES = BUDGET_CYCLES + 200;

    logic                clock;
    logic                arst_n;
    logic [`XLEN-1:0]    address_imem;
    logic [`XLEN-1:0]    q_imem;
    logic [`XLEN-1:0]    address_dmem;
    logic [`XLEN-1:0]    data;
    logic                wren;
    logic [`XLEN-1:0]    q_dmem;
    logic                ctrl_writeEnable;
    logic [`REG_W-1:0]   ctrl_writeReg;
    logic [`REG_W-1:0]   ctrl_readRegA;
    logic [`REG_W-1:0]   ctrl_readRegB;
    logic [`XLEN-1:0]    data_writeReg;
    logic [`XLEN-1:0]    data_readRegA;
    logic [`XLEN-1:0]    data_readRegB;
    logic [`POS_W-1:0]   player_x;
    logic [`POS_W-1:0]   player_y;
    logic [`XLEN-1:0]    difficulty;
    int                  mismatches;
    int                  failures;

    processor u_processor (
        .clock            (clock),
        .arst_n           (arst_n),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB),
        .player_x         (player_x),
        .player_y         (player_y),
        .difficulty       (difficulty)
    );

    tb_system_model u_model (
        .clock            (clock),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Register 0 must never be a write destination
    always @(negedge clock) begin
        if (arst_n === 1'b1 && ctrl_writeEnable === 1'b1 && ctrl_writeReg == '0) begin
            failures++;
            $display("Register write enabled with destination register 0 at %0t", $time);
        end
    end

    function automatic logic [31:0] r_type(logic [4:0] alu, logic [4:0] rd, logic [4:0] rs,
                                           logic [4:0] rt, logic [4:0] shamt);
        return {OP_RTYPE, rd, rs, rt, shamt, alu, 2'b00};
    endfunction

    function automatic logic [31:0] i_type(logic [4:0] op, logic [4:0] rd, logic [4:0] rs,
                                           logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [31:0] j_type(logic [26:0] target);
        return {OP_J, target};
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_reg(int idx, logic [31:0] exp);
        compare_value($sformatf("regs[%0d]", idx), u_model.regs[idx], exp);
    endtask

    task automatic compare_mem(int addr, logic [31:0] exp);
        compare_value($sformatf("dmem[%0d]", addr), u_model.dmem[addr], exp);
    endtask

    // Core is held in reset while the model is reloaded
    task automatic hold_reset();
        @(posedge clock);
        #1;
        arst_n = 1'b0;
        u_model.clear_contents();
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_program(int len);
        repeat (4 * len + 20) @(posedge clock);
        #1;
    endtask

    task automatic alu_chain_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e [3:10];
        a = $urandom();
        b = $urandom();
        hold_reset();
        u_model.regs[1] = a;
        u_model.regs[2] = b;
        u_model.imem[0] = r_type(ALU_ADD, 3, 1, 2, 0);
        u_model.imem[1] = r_type(ALU_SUB, 4, 3, 1, 0);
        u_model.imem[2] = r_type(ALU_AND, 5, 4, 3, 0);
        u_model.imem[3] = r_type(ALU_OR, 6, 5, 2, 0);
        u_model.imem[4] = r_type(ALU_SLL, 7, 6, 0, 3);
        u_model.imem[5] = r_type(ALU_SRA, 8, 7, 0, 5);
        // addi with -5
        u_model.imem[6] = i_type(OP_ADDI, 9, 8, 17'h1_fffb);
        u_model.imem[7] = r_type(ALU_ADD, 10, 9, 7, 0);
        u_model.imem[8] = j_type(8);
        release_reset();
        run_program(LEN_ALU);
        e[3] = a + b;
        e[4] = e[3] - a;
        e[5] = e[4] & e[3];
        e[6] = e[5] | b;
        e[7] = e[6] << 3;
        e[8] = $signed(e[7]) >>> 5;
        e[9] = e[8] - 32'd5;
        e[10] = e[9] + e[7];
        for (int i = 3; i <= 10; i++) begin
            compare_reg(i, e[i]);
        end
    endtask

    task automatic load_store_test();
        int          base;
        logic [31:0] v;
        logic [31:0] w;
        base = $urandom_range(0, 200);
        v = $urandom();
        w = $urandom();
        hold_reset();
        u_model.regs[1] = base;
        u_model.regs[2] = v;
        u_model.regs[3] = w;
        u_model.imem[0] = i_type(OP_ADDI, 4, 2, 7);
        u_model.imem[1] = i_type(OP_SW, 4, 1, 3);
        u_model.imem[2] = i_type(OP_LW, 5, 1, 3);
        // Load-use bubble expected here
        u_model.imem[3] = r_type(ALU_ADD, 6, 5, 3, 0);
        u_model.imem[4] = i_type(OP_LW, 7, 1, 3);
        u_model.imem[5] = i_type(OP_SW, 7, 1, 10);
        u_model.imem[6] = i_type(OP_LW, 8, 1, 10);
        u_model.imem[7] = j_type(7);
        release_reset();
        run_program(LEN_MEM);
        compare_mem(base + 3, v + 7);
        compare_mem(base + 10, v + 7);
        compare_reg(4, v + 7);
        compare_reg(5, v + 7);
        compare_reg(6, v + 7 + w);
        compare_reg(7, v + 7);
        compare_reg(8, v + 7);
    endtask

    task automatic branch_test();
        logic [31:0] x;
        x = $urandom_range(0, 32'hffff);
        hold_reset();
        u_model.regs[1] = x;
        u_model.regs[2] = x;
        u_model.regs[3] = x + 5;
        u_model.imem[0] = i_type(OP_BNE, 1, 2, 2);
        u_model.imem[1] = i_type(OP_ADDI, 10, 0, 10);
        u_model.imem[2] = i_type(OP_BNE, 3, 1, 2);
        u_model.imem[3] = i_type(OP_ADDI, 11, 0, 11);
        u_model.imem[4] = i_type(OP_ADDI, 12, 0, 12);
        u_model.imem[5] = i_type(OP_BLT, 3, 1, 2);
        u_model.imem[6] = i_type(OP_ADDI, 13, 0, 13);
        u_model.imem[7] = i_type(OP_BLT, 1, 3, 2);
        u_model.imem[8] = i_type(OP_ADDI, 14, 0, 14);
        u_model.imem[9] = i_type(OP_ADDI, 15, 0, 15);
        u_model.imem[10] = j_type(14);
        u_model.imem[11] = i_type(OP_ADDI, 16, 0, 16);
        u_model.imem[12] = i_type(OP_ADDI, 17, 0, 17);
        u_model.imem[13] = i_type(OP_ADDI, 18, 0, 18);
        u_model.imem[14] = i_type(OP_ADDI, 19, 0, 19);
        u_model.imem[15] = j_type(15);
        release_reset();
        run_program(LEN_BRANCH);
        // Only the fall-through and target slots leave a mark
        for (int i = 10; i <= 19; i++) begin
            compare_reg(i, (i == 10 || i == 13 || i == 19) ? i : 0);
        end
    endtask

    task automatic game_read_test();
        logic [8:0]  px;
        logic [8:0]  py;
        logic [31:0] dif;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        px = $urandom();
        py = $urandom();
        dif = $urandom();
        hold_reset();
        player_x = px;
        player_y = py;
        difficulty = dif;
        u_model.imem[0] = r_type(GAME_PLX, 1, 0, 0, 0);
        u_model.imem[1] = r_type(GAME_PLY, 2, 0, 0, 0);
        u_model.imem[2] = r_type(GAME_DIF, 3, 0, 0, 0);
        u_model.imem[3] = r_type(GAME_RND, 4, 0, 0, 0);
        u_model.imem[4] = r_type(GAME_RND, 5, 0, 0, 0);
        u_model.imem[5] = r_type(ALU_ADD, 6, 1, 2, 0);
        u_model.imem[6] = j_type(6);
        release_reset();
        run_program(LEN_GAME);
        compare_reg(1, {23'd0, px});
        compare_reg(2, {23'd0, py});
        compare_reg(3, dif);
        compare_reg(6, {23'd0, px} + {23'd0, py});
        rnd_a = u_model.regs[4];
        rnd_b = u_model.regs[5];
        if ($isunknown(rnd_a) || rnd_a == '0 || $isunknown(rnd_b) || rnd_b == '0) begin
            failures++;
            $display("A random read returned zero or an unknown value");
        end
        if (rnd_a === rnd_b) begin
            failures++;
            $display("Two random reads returned the same value");
        end
    endtask

    task automatic reset_write_test();
        hold_reset();
        u_model.imem[0] = i_type(OP_ADDI, 1, 0, 17'h55);
        u_model.imem[1] = i_type(OP_SW, 1, 2, 20);
        u_model.imem[2] = j_type(2);
        release_reset();
        // Nothing reaches the write ports before the fourth edge
        for (int k = 0; k < 4; k++) begin
            @(negedge clock);
            if (wren !== 1'b0 || ctrl_writeEnable !== 1'b0) begin
                failures++;
                $display("Write strobe high %0d cycles after reset, before any write", k);
            end
            compare_value("address_imem", address_imem, k);
            // The store sits in decode two cycles in
            if (k == 2) begin
                compare_value("ctrl_readRegA", ctrl_readRegA, 2);
                compare_value("ctrl_readRegB", ctrl_readRegB, 1);
            end
        end
        @(negedge clock);
        compare_value("ctrl_writeEnable", ctrl_writeEnable, 1);
        compare_value("ctrl_writeReg", ctrl_writeReg, 1);
        compare_value("data_writeReg", data_writeReg, 32'h55);
        compare_value("wren", wren, 1);
        compare_value("address_dmem", address_dmem, 20);
        compare_value("data", data, 32'h55);
        repeat (4 * LEN_RESET + 20 - 5) @(posedge clock);
        #1;
        compare_reg(1, 32'h55);
        compare_mem(20, 32'h55);
    endtask

    initial begin
        arst_n = 1'b0;
        player_x = '0;
        player_y = '0;
        difficulty = '0;
        mismatches = 0;
        failures = 0;
        void'($urandom(32'hf287_2de3));
        alu_chain_test();
        load_store_test();
        branch_test();
        game_read_test();
        reset_write_test();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verification/tb_system_model.sv */
`include "proc_consts.svh"

// Instruction memory, data memory and register file around the core
module tb_system_model (
    input  logic                clock,
    input  logic [`XLEN-1:0]    address_imem,
    output logic [`XLEN-1:0]    q_imem,
    input  logic [`XLEN-1:0]    address_dmem,
    input  logic [`XLEN-1:0]    data,
    input  logic                wren,
    output logic [`XLEN-1:0]    q_dmem,
    input  logic                ctrl_writeEnable,
    input  logic [`REG_W-1:0]   ctrl_writeReg,
    input  logic [`REG_W-1:0]   ctrl_readRegA,
    input  logic [`REG_W-1:0]   ctrl_readRegB,
    input  logic [`XLEN-1:0]    data_writeReg,
    output logic [`XLEN-1:0]    data_readRegA,
    output logic [`XLEN-1:0]    data_readRegB
);

    localparam int MEM_WORDS = 256;

    logic [`XLEN-1:0] imem [0:MEM_WORDS-1];
    logic [`XLEN-1:0] dmem [0:MEM_WORDS-1];
    logic [`XLEN-1:0] regs [0:31];

    // Combinational reads, word addressed
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Register 0 always reads as zero
    assign data_readRegA = (ctrl_readRegA == '0) ? '0 : regs[ctrl_readRegA];
    assign data_readRegB = (ctrl_readRegB == '0) ? '0 : regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (wren === 1'b1) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_writeEnable === 1'b1 && ctrl_writeReg != '0) begin
            regs[ctrl_writeReg] <= data_writeReg;
        end
    end

    // Empty program is all bubbles, data words carry their own address
    task automatic clear_contents();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd5a0_0000 ^ (i << 8) ^ i;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
    endtask

endmodule
